// File: design/cpu_macros.svh
// Widths assume two 16-bit instructions per 32-bit fetch word and must be changed together
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath and fetch widths
////////////////////////////////////////////////////////////////////////////

`define CPU_WORD_W    16
`define CPU_FETCH_W   32
`define CPU_PC_W      16

////////////////////////////////////////////////////////////////////////////
// Register file
////////////////////////////////////////////////////////////////////////////

`define CPU_REG_AW    3
`define CPU_NUM_REGS  8
// Hardwired zero, writes are dropped
`define CPU_ZERO_REG  7

// All ones so the first address after reset wraps to 0
`define CPU_PC_RESET  {`CPU_PC_W{1'b1}}

`endif

// File: design/cpu_pkg.sv
// Only the four ADD/SUB opcodes are defined and any other opcode value executes as NOP
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

   typedef enum logic [4:0] {
      OP_ADDI = 5'b00000,
      OP_ADD  = 5'b00001,
      OP_SUBI = 5'b00010,
      OP_SUB  = 5'b00011
   } opcode_e;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_NOP = 2'd2
   } alu_op_e;

   ////////////////////////////////////////////////////////////////////////////
   // Instruction formats
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      opcode_e                opcode;
      logic [`CPU_REG_AW-1:0] rd;
      logic [`CPU_REG_AW-1:0] rs;
      logic [1:0]             unused;
      logic [`CPU_REG_AW-1:0] rt;
   } reg_form_t;

   typedef struct packed {
      opcode_e                opcode;
      logic [`CPU_REG_AW-1:0] rd;
      logic [`CPU_REG_AW-1:0] rs;
      logic [4:0]             imm;
   } imm_form_t;

   // Same word, the opcode picks the view
   typedef union packed {
      reg_form_t r;
      imm_form_t i;
   } instr_t;

   // First instruction sits in the low half, as in memory
   typedef struct packed {
      instr_t second;
      instr_t first;
   } instr_pair_t;

   ////////////////////////////////////////////////////////////////////////////
   // Lane traffic
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [`CPU_REG_AW-1:0] a;
      logic [`CPU_REG_AW-1:0] b;
   } read_addr_t;

   typedef struct packed {
      logic [`CPU_WORD_W-1:0] a;
      logic [`CPU_WORD_W-1:0] b;
   } read_data_t;

   typedef struct packed {
      alu_op_e                alu_op;
      logic [`CPU_REG_AW-1:0] dest;
      logic [`CPU_WORD_W-1:0] arg_a;
      logic [`CPU_WORD_W-1:0] arg_b;
   } lane_op_t;

   typedef struct packed {
      logic                   en;
      logic [`CPU_REG_AW-1:0] addr;
      logic [`CPU_WORD_W-1:0] value;
   } wb_t;

endpackage

`default_nettype wire

// File: design/fetch_buffer.sv
// Memory must return the word for the previous cycle's instr_addr and there is no external stall
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module fetch_buffer import cpu_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    issue_one,
   input  logic [`CPU_FETCH_W-1:0] instr_word,
   output logic [`CPU_PC_W-1:0]    instr_addr,
   output logic [`CPU_PC_W-1:0]    pc,
   output logic                    stall,
   output instr_pair_t             window
);

   instr_t word_lo;
   instr_t word_hi;
   instr_t carry;
   logic   carry_full;

   assign word_lo = instr_word[`CPU_WORD_W-1:0];
   assign word_hi = instr_word[`CPU_FETCH_W-1:`CPU_WORD_W];

   ////////////////////////////////////////////////////////////////////////////
   // Window selection
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      if (carry_full) begin
         window.first  = carry;
         window.second = word_lo;
      end else begin
         window.first  = word_lo;
         window.second = word_hi;
      end
   end

   // Carry plus an unissued low half means the word must be read again
   assign stall      = carry_full && issue_one;
   assign instr_addr = stall ? pc : pc + `CPU_PC_W'(1);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= `CPU_PC_RESET;
      end else begin
         pc <= instr_addr;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Carry slot
   ////////////////////////////////////////////////////////////////////////////

   // Empty and single issue fills it, full and single issue drains it
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         carry_full <= 1'b0;
      end else begin
         carry_full <= carry_full ^ issue_one;
      end
   end

   // Every transition into the full state keeps the high half
   always_ff @(posedge clk) begin
      if (carry_full != issue_one) begin
         carry <= word_hi;
      end
   end

endmodule

`default_nettype wire

// File: design/pair_decoder.sv
// Dependency check compares register fields only and does not look at whether the first writes
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module pair_decoder import cpu_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  instr_pair_t window,
   output read_addr_t  rd_addr_1,
   output read_addr_t  rd_addr_2,
   input  read_data_t  rd_data_1,
   input  read_data_t  rd_data_2,
   output logic        issue_one,
   output lane_op_t    lane_1,
   output lane_op_t    lane_2
);

   instr_t   first;
   instr_t   second;
   lane_op_t next_1;
   lane_op_t next_2;

   ////////////////////////////////////////////////////////////////////////////
   // Field decode
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic uses_rt(input instr_t ins);
      return (ins.r.opcode == OP_ADD) || (ins.r.opcode == OP_SUB);
   endfunction

   function automatic logic [`CPU_WORD_W-1:0] sext_imm(input logic [4:0] imm);
      return {{(`CPU_WORD_W-5){imm[4]}}, imm};
   endfunction

   function automatic lane_op_t decode_lane(input instr_t ins, input read_data_t src);
      lane_op_t op;
      op.alu_op = ALU_NOP;
      op.dest   = ins.r.rd;
      op.arg_a  = src.a;
      op.arg_b  = src.b;
      case (ins.r.opcode)
         OP_ADDI: begin
            op.alu_op = ALU_ADD;
            op.arg_b  = sext_imm(ins.i.imm);
         end
         OP_ADD:  op.alu_op = ALU_ADD;
         OP_SUBI: begin
            op.alu_op = ALU_SUB;
            op.arg_b  = sext_imm(ins.i.imm);
         end
         OP_SUB:  op.alu_op = ALU_SUB;
         default: op.alu_op = ALU_NOP;
      endcase
      return op;
   endfunction

   assign first  = window.first;
   assign second = window.second;

   // rt read even for immediates, the value is simply not used
   assign rd_addr_1 = '{a: first.r.rs, b: first.r.rt};
   assign rd_addr_2 = '{a: second.r.rs, b: second.r.rt};

   // Second reads what the first is about to write
   assign issue_one = (second.r.rs == first.r.rd) ||
                      (uses_rt(second) && (second.r.rt == first.r.rd));

   always_comb begin
      next_1 = decode_lane(first, rd_data_1);
      next_2 = decode_lane(second, rd_data_2);
      if (issue_one) begin
         next_2.alu_op = ALU_NOP;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Decode to execute register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lane_1 <= '{alu_op: ALU_NOP, dest: '0, arg_a: '0, arg_b: '0};
         lane_2 <= '{alu_op: ALU_NOP, dest: '0, arg_a: '0, arg_b: '0};
      end else begin
         lane_1 <= next_1;
         lane_2 <= next_2;
      end
   end

endmodule

`default_nettype wire

// File: design/execute_lanes.sv
// Purely combinational and results wrap modulo 2^16 with no overflow flag
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module execute_lanes import cpu_pkg::*; (
   input  lane_op_t lane_1,
   input  lane_op_t lane_2,
   output wb_t      wb_1,
   output wb_t      wb_2
);

   // One lane of ADD/SUB, NOP gives no write
   function automatic wb_t run_lane(input lane_op_t op);
      wb_t wb;
      wb.en    = 1'b0;
      wb.addr  = op.dest;
      wb.value = '0;
      case (op.alu_op)
         ALU_ADD: begin
            wb.en    = 1'b1;
            wb.value = op.arg_a + op.arg_b;
         end
         ALU_SUB: begin
            wb.en    = 1'b1;
            wb.value = op.arg_a - op.arg_b;
         end
         default: wb.en = 1'b0;
      endcase
      return wb;
   endfunction

   assign wb_1 = run_lane(lane_1);
   assign wb_2 = run_lane(lane_2);

endmodule

`default_nettype wire

// File: design/reg_file.sv
// Register contents are undefined until the first reset and the debug port bypasses forwarding
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module reg_file import cpu_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,
   input  wb_t                    wb_1,
   input  wb_t                    wb_2,
   input  read_addr_t             rd_addr_1,
   input  read_addr_t             rd_addr_2,
   output read_data_t             rd_data_1,
   output read_data_t             rd_data_2,
   input  logic [`CPU_REG_AW-1:0] dbg_addr,
   output logic [`CPU_WORD_W-1:0] dbg_value
);

   logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];

   // Zero register never accepts a write
   function automatic logic writable(input wb_t w);
      return w.en && (w.addr != `CPU_ZERO_REG);
   endfunction

   // Lane 2 is applied last so it wins on a shared address
   function automatic logic [`CPU_WORD_W-1:0] forward(
      input logic [`CPU_REG_AW-1:0] addr,
      input logic [`CPU_WORD_W-1:0] stored,
      input wb_t                    w1,
      input wb_t                    w2
   );
      logic [`CPU_WORD_W-1:0] value;
      value = stored;
      if (writable(w1) && (w1.addr == addr)) begin
         value = w1.value;
      end
      if (writable(w2) && (w2.addr == addr)) begin
         value = w2.value;
      end
      return value;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Write ports
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (writable(wb_1)) begin
            regs[wb_1.addr] <= wb_1.value;
         end
         // Later assignment, so lane 2 overrides lane 1
         if (writable(wb_2)) begin
            regs[wb_2.addr] <= wb_2.value;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read ports
   ////////////////////////////////////////////////////////////////////////////

   assign rd_data_1.a = forward(rd_addr_1.a, regs[rd_addr_1.a], wb_1, wb_2);
   assign rd_data_1.b = forward(rd_addr_1.b, regs[rd_addr_1.b], wb_1, wb_2);
   assign rd_data_2.a = forward(rd_addr_2.a, regs[rd_addr_2.a], wb_1, wb_2);
   assign rd_data_2.b = forward(rd_addr_2.b, regs[rd_addr_2.b], wb_1, wb_2);

   assign dbg_value = regs[dbg_addr];

endmodule

`default_nettype wire

// File: design/dual_issue_core.sv
// Instruction memory is external with one cycle read latency and retire bit 0 belongs to lane 1
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module dual_issue_core import cpu_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n,
   output logic [`CPU_PC_W-1:0]    instr_addr,
   input  logic [`CPU_FETCH_W-1:0] instr_word,
   input  logic [`CPU_REG_AW-1:0]  dbg_addr,
   output logic [`CPU_WORD_W-1:0]  dbg_value,
   output logic [`CPU_PC_W-1:0]    pc,
   output logic                    stall,
   output logic [1:0]              retire
);

   instr_pair_t window;
   logic        issue_one;
   read_addr_t  rd_addr_1;
   read_addr_t  rd_addr_2;
   read_data_t  rd_data_1;
   read_data_t  rd_data_2;
   lane_op_t    lane_1;
   lane_op_t    lane_2;
   wb_t         wb_1;
   wb_t         wb_2;

   ////////////////////////////////////////////////////////////////////////////
   // Fetch and decode
   ////////////////////////////////////////////////////////////////////////////

   fetch_buffer fetch0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue_one  (issue_one),
      .instr_word (instr_word),
      .instr_addr (instr_addr),
      .pc         (pc),
      .stall      (stall),
      .window     (window)
   );

   pair_decoder decode0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .window    (window),
      .rd_addr_1 (rd_addr_1),
      .rd_addr_2 (rd_addr_2),
      .rd_data_1 (rd_data_1),
      .rd_data_2 (rd_data_2),
      .issue_one (issue_one),
      .lane_1    (lane_1),
      .lane_2    (lane_2)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Execute and writeback
   ////////////////////////////////////////////////////////////////////////////

   execute_lanes exec0 (
      .lane_1 (lane_1),
      .lane_2 (lane_2),
      .wb_1   (wb_1),
      .wb_2   (wb_2)
   );

   reg_file regs0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .wb_1      (wb_1),
      .wb_2      (wb_2),
      .rd_addr_1 (rd_addr_1),
      .rd_addr_2 (rd_addr_2),
      .rd_data_1 (rd_data_1),
      .rd_data_2 (rd_data_2),
      .dbg_addr  (dbg_addr),
      .dbg_value (dbg_value)
   );

   // High while the execute cycle writes back
   assign retire = {wb_2.en, wb_1.en};

endmodule

`default_nettype wire

// File: verification/dual_issue_props.sv
// Bound into the core top level, the reset checks look only at the first cycle after release
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module dual_issue_props import cpu_pkg::*; (
   input logic                 clk,
   input logic                 rst_n,
   input logic [`CPU_PC_W-1:0] pc,
   input logic [`CPU_PC_W-1:0] instr_addr,
   input logic                 stall,
   input lane_op_t             lane_1,
   input lane_op_t             lane_2
);

   // A stalled fetch reads the same word again and then moves on
   a_stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
      stall |=> (!stall && (pc == $past(pc)) &&
                 (instr_addr == $past(pc) + `CPU_PC_W'(1))))
      else $error("fetch did not resume after a stall");

   a_no_stall_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !stall)
      else $error("stall high in the first cycle after reset");

   a_lanes_nop_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> ((lane_1.alu_op == ALU_NOP) && (lane_2.alu_op == ALU_NOP)))
      else $error("lane not NOP in the first cycle after reset");

endmodule

bind dual_issue_core dual_issue_props props0 (
   .clk        (clk),
   .rst_n      (rst_n),
   .pc         (pc),
   .instr_addr (instr_addr),
   .stall      (stall),
   .lane_1     (lane_1),
   .lane_2     (lane_2)
);

`default_nettype wire

// File: verification/tb_dual_issue.sv
// Memory model holds 64 words and returns zero beyond them, the reference model assumes only ADD/SUB
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module tb_dual_issue;

   localparam int MEM_WORDS = 64;
   localparam int TIMEOUT   = 500;

   logic                    clk;
   logic                    rst_n;
   logic [`CPU_PC_W-1:0]    instr_addr;
   logic [`CPU_FETCH_W-1:0] instr_word;
   logic [`CPU_REG_AW-1:0]  dbg_addr;
   logic [`CPU_WORD_W-1:0]  dbg_value;
   logic [`CPU_PC_W-1:0]    pc;
   logic                    stall;
   logic [1:0]              retire;

   logic [`CPU_FETCH_W-1:0] mem [MEM_WORDS];
   logic [`CPU_WORD_W-1:0]  prog [$];
   logic [`CPU_WORD_W-1:0]  exp_regs [`CPU_NUM_REGS];
   logic [31:0]             lcg_state;
   logic                    watch;
   logic                    saw_stall;
   logic                    saw_dual;

   dual_issue_core dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .instr_addr (instr_addr),
      .instr_word (instr_word),
      .dbg_addr   (dbg_addr),
      .dbg_value  (dbg_value),
      .pc         (pc),
      .stall      (stall),
      .retire     (retire)
   );

   always #10 clk = ~clk;

   // Synchronous instruction memory, one cycle latency
   always @(posedge clk) begin
      if (!rst_n) begin
         instr_word <= '0;
      end else if (instr_addr < MEM_WORDS) begin
         instr_word <= mem[instr_addr];
      end else begin
         instr_word <= '0;
      end
   end

   // Sticky flags, sampled well after the edge
   always begin
      @(posedge clk);
      #5;
      if (watch && stall) saw_stall = 1'b1;
      if (watch && (retire == 2'b11)) saw_dual = 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [15:0] enc_reg(input logic [4:0] op, input int rd, rs, rt);
      return {op, rd[2:0], rs[2:0], 2'b00, rt[2:0]};
   endfunction

   function automatic logic [15:0] enc_imm(input logic [4:0] op, input int rd, rs, imm);
      return {op, rd[2:0], rs[2:0], imm[4:0]};
   endfunction

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic fail_now(input string msg);
      $display("Fail at %0t ns: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped after a failed check");
   endtask

   task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
      assert (got === exp) else fail_now($sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   // Sequential execution of the program, one instruction at a time
   task automatic compute_reference();
      logic [15:0] ins;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] sx;
      for (int r = 0; r < `CPU_NUM_REGS; r++) exp_regs[r] = '0;
      foreach (prog[i]) begin
         ins = prog[i];
         a   = exp_regs[ins[7:5]];
         b   = exp_regs[ins[2:0]];
         sx  = {{11{ins[4]}}, ins[4:0]};
         if ((ins[15:11] <= 5'd3) && (ins[10:8] != `CPU_ZERO_REG)) begin
            case (ins[15:11])
               5'd0:    exp_regs[ins[10:8]] = a + sx;
               5'd1:    exp_regs[ins[10:8]] = a + b;
               5'd2:    exp_regs[ins[10:8]] = a - sx;
               default: exp_regs[ins[10:8]] = a - b;
            endcase
         end
      end
   endtask

   task automatic load_program();
      for (int w = 0; w < MEM_WORDS; w++) mem[w] = '0;
      foreach (prog[i]) begin
         if (i % 2 == 1) mem[i/2][31:16] = prog[i];
         else mem[i/2][15:0] = prog[i];
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic wait_for_end(input int nwords);
      int  cycles;
      logic done;
      cycles = 0;
      done   = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (pc == nwords[15:0]) begin
            done = 1'b1;
         end else begin
            cycles++;
            if (cycles > TIMEOUT) begin
               $display("Timeout: pc never reached the end of the program at %0t ns", $time);
               $display("RESULT: FAIL");
               $fatal(1, "Simulation stopped on a timeout");
            end
         end
      end
   endtask

   task automatic check_registers(input string test);
      for (int r = 0; r < `CPU_NUM_REGS; r++) begin
         @(negedge clk);
         dbg_addr = r[2:0];
         #5;
         check_value($sformatf("%s r%0d", test, r), dbg_value, exp_regs[r]);
      end
   endtask

   task automatic run_program(input string test);
      load_program();
      compute_reference();
      saw_stall = 1'b0;
      saw_dual  = 1'b0;
      apply_reset();
      watch = 1'b1;
      wait_for_end((prog.size() + 1) / 2);
      watch = 1'b0;
      repeat (4) @(negedge clk);
      check_registers(test);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_reset();
      prog.delete();
      load_program();
      compute_reference();
      apply_reset();
      #5;
      assert (!stall && (retire == 2'b00))
         else fail_now($sformatf("stall %b retire %b after reset", stall, retire));
      check_registers("reset");
   endtask

   task automatic test_immediate();
      prog = '{enc_imm(0, 1, 7, -3), enc_imm(2, 2, 7, -7), enc_imm(0, 3, 7, -16),
               enc_imm(2, 4, 1, -5), enc_imm(0, 5, 2, -1), enc_imm(2, 6, 3, 9),
               enc_imm(0, 1, 4, -8), enc_imm(2, 2, 5, -2)};
      run_program("immediate");
      assert (!saw_stall) else fail_now("stall rose on independent instructions");
      assert (saw_dual) else fail_now("no cycle retired both lanes");
   endtask

   task automatic test_dependency();
      prog = '{enc_imm(0, 1, 7, 5), enc_reg(1, 2, 1, 1), enc_reg(3, 3, 2, 1),
               enc_reg(1, 4, 3, 2), enc_imm(2, 5, 4, -3), enc_reg(1, 6, 5, 4),
               enc_reg(1, 1, 6, 5), enc_reg(3, 2, 1, 6)};
      run_program("dependency");
      assert (saw_stall) else fail_now("stall never rose on a dependent chain");
   endtask

   task automatic test_write_rules();
      prog = '{enc_imm(0, 7, 7, 5), enc_imm(0, 2, 7, 3), enc_imm(0, 2, 7, -4),
               enc_imm(0, 3, 7, 1), enc_imm(0, 7, 7, 9), enc_reg(1, 4, 7, 7),
               enc_imm(0, 5, 2, 0)};
      run_program("write rules");
      // Lane 2 value must survive, r7 stays zero
      @(negedge clk);
      dbg_addr = 3'd2;
      #5;
      check_value("r2 after shared write", dbg_value, 16'hfffc);
      @(negedge clk);
      dbg_addr = 3'd7;
      #5;
      check_value("r7 after writes", dbg_value, 16'h0000);
   endtask

   task automatic test_random();
      logic [31:0] rnd;
      prog.delete();
      for (int i = 0; i < 40; i++) begin
         rnd = lcg_next();
         if (rnd[17]) prog.push_back(enc_reg({3'b000, rnd[16], 1'b1}, rnd[26:24],
                                             rnd[22:20], rnd[30:28]));
         else prog.push_back(enc_imm({3'b000, rnd[16], 1'b0}, rnd[26:24],
                                     rnd[22:20], int'(rnd[12:8])));
      end
      run_program("random");
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      dbg_addr   = '0;
      instr_word = '0;
      watch      = 1'b0;
      saw_stall  = 1'b0;
      saw_dual   = 1'b0;
      lcg_state  = 32'd82288;
      test_reset();
      test_immediate();
      test_dependency();
      test_write_rules();
      test_random();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/cpu_pkg.sv
design/fetch_buffer.sv
design/pair_decoder.sv
design/execute_lanes.sv
design/reg_file.sv
design/dual_issue_core.sv
verification/dual_issue_props.sv
verification/tb_dual_issue.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_dual_issue
FILELIST  = tb.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
